/* hdl/mecobo_pkg.sv */
// shared sizes, command words and sample records for the board controller
`default_nettype none

package mecobo_pkg;

  // number of waveform pins
  localparam int NUM_PINS = 16;
  // command queue entries
  localparam int FIFO_DEPTH = 8;
  // result queue entries
  localparam int RES_DEPTH = 4;

  // free running global time
  typedef logic [31:0] time_t;

  // command kind, value 3 never valid
  typedef enum logic [1:0] {
    KIND_PIN          = 2'd0,
    KIND_TIME_RESTART = 2'd1,
    KIND_SAMPLE       = 2'd2
  } cmd_kind_e;

  // register select inside one pin controller
  typedef enum logic [1:0] {
    REG_MODE   = 2'd0,
    REG_PERIOD = 2'd1,
    REG_DUTY   = 2'd2
  } pin_reg_e;

  // waveform generated on a pin
  typedef enum logic [1:0] {
    WAVE_LOW    = 2'd0,
    WAVE_HIGH   = 2'd1,
    WAVE_SQUARE = 2'd2,
    WAVE_PWM    = 2'd3
  } wave_mode_e;

  // body of a pin register write
  typedef struct packed {
    logic [1:0]  kind;
    logic [3:0]  pin;
    pin_reg_e    reg_sel;
    logic [7:0]  pad;
    logic [15:0] value;
  } pin_cmd_t;

  // body of restart and sample, only the kind matters
  typedef struct packed {
    logic [1:0]  kind;
    logic [29:0] reserved;
  } ctrl_cmd_t;

  // same 32 bits, kind on top in both views
  typedef union packed {
    pin_cmd_t  pin;
    ctrl_cmd_t ctrl;
  } cmd_body_u;

  // full 64-bit host command, start time in the upper word
  typedef struct packed {
    time_t     start;
    cmd_body_u body;
  } sched_cmd_t;

  // broadcast register write to the pin controllers
  typedef struct packed {
    logic [3:0]  pin;
    pin_reg_e    reg_sel;
    logic [15:0] value;
  } pin_write_t;

  // captured time and pin levels
  typedef struct packed {
    time_t                stamp;
    logic [NUM_PINS-1:0]  levels;
  } sample_rec_t;

endpackage

`default_nettype wire

/* hdl/host_cmd_decode.sv */
// host command port, four-phase handshake and kind check before queueing
`timescale 1ns/10ps
`default_nettype none

module host_cmd_decode (
  input  wire                     sys_clk,
  input  wire                     global_clock_reset,
  input  wire                     cmd_req,
  input  wire mecobo_pkg::sched_cmd_t cmd,
  output logic                    cmd_ack,
  output logic                    bad_cmd,
  input  wire                     fifo_full,
  output logic                    push,
  output mecobo_pkg::sched_cmd_t  push_data
);

  import mecobo_pkg::*;

  logic accept;
  logic legal;

  // kind read through the control view of the body
  assign legal = cmd.body.ctrl.kind inside {KIND_PIN, KIND_TIME_RESTART, KIND_SAMPLE};

  // fresh request, not yet acked
  // full queue holds the ack back
  assign accept = cmd_req && !cmd_ack && !fifo_full;

  // one push per handshake, illegal kinds dropped
  assign push      = accept && legal;
  assign push_data = cmd;

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      cmd_ack <= 1'b0;
      bad_cmd <= 1'b0;
    end else begin
      // raise on accept, drop once the host lets go
      if (accept) begin
        cmd_ack <= 1'b1;
      end else if (!cmd_req) begin
        cmd_ack <= 1'b0;
      end
      // sticky flag
      if (accept && !legal) begin
        bad_cmd <= 1'b1;
      end
    end
  end

  // host must hold the command until it sees the ack
  a_cmd_stable : assert property (
    @(posedge sys_clk) disable iff (global_clock_reset)
    (cmd_req && !cmd_ack) |=> (cmd_ack || !cmd_req || $stable(cmd))
  ) else $error("cmd changed while cmd_req pending");

endmodule

`default_nettype wire

/* hdl/cmd_fifo.sv */
// command queue between the host decode and the scheduler
`timescale 1ns/10ps
`default_nettype none

module cmd_fifo (
  input  wire                     sys_clk,
  input  wire                     global_clock_reset,
  input  wire                     push,
  input  wire mecobo_pkg::sched_cmd_t push_data,
  input  wire                     pop,
  output mecobo_pkg::sched_cmd_t  head,
  output logic                    full,
  output logic                    empty
);

  import mecobo_pkg::*;

  // storage, no reset needed
  sched_cmd_t mem [FIFO_DEPTH];

  // pointers wrap on their own, depth is a power of two
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count;

  assign head  = mem[rd_ptr];
  assign full  = (count == FIFO_DEPTH);
  assign empty = (count == 0);

  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      // occupancy, simultaneous push and pop cancel
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  a_no_overflow : assert property (
    @(posedge sys_clk) disable iff (global_clock_reset) push |-> !full
  ) else $error("push into full command fifo");

  a_no_underflow : assert property (
    @(posedge sys_clk) disable iff (global_clock_reset) pop |-> !empty
  ) else $error("pop from empty command fifo");

endmodule

`default_nettype wire

/* hdl/sched_execute.sv */
// global time counter and scheduler that dispatches queued commands on time
`timescale 1ns/10ps
`default_nettype none

module sched_execute (
  input  wire                          sys_clk,
  input  wire                          global_clock_reset,
  input  wire mecobo_pkg::sched_cmd_t  head,
  input  wire                          empty,
  output logic                         pop,
  output logic                         pin_wr,
  output mecobo_pkg::pin_write_t       pin_wr_data,
  input  wire [mecobo_pkg::NUM_PINS-1:0] pins,
  input  wire                          rec_full,
  output logic                         rec_push,
  output mecobo_pkg::sample_rec_t      rec_data
);

  import mecobo_pkg::*;

  time_t now;
  logic  due;
  logic  is_pin;
  logic  is_restart;
  logic  is_sample;

  // head is due once its start time is reached or passed
  assign due = !empty && (head.start <= now);

  // kind decode through the control view
  assign is_pin     = (head.body.ctrl.kind == KIND_PIN);
  assign is_restart = (head.body.ctrl.kind == KIND_TIME_RESTART);
  assign is_sample  = (head.body.ctrl.kind == KIND_SAMPLE);

  // sample stalls while the result queue is full
  // everything behind it waits too
  assign pop = due && !(is_sample && rec_full);

  // capture this cycle's time and levels
  assign rec_push = pop && is_sample;
  assign rec_data = '{stamp: now, levels: pins};

  // global time, restart reads zero next cycle
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      now <= '0;
    end else if (pop && is_restart) begin
      now <= '0;
    end else begin
      now <= now + 1'b1;
    end
  end

  // pin write strobe, one cycle after execution
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      pin_wr <= 1'b0;
    end else begin
      pin_wr <= pop && is_pin;
    end
  end

  // payload through the pin view of the body
  always_ff @(posedge sys_clk) begin
    if (pop && is_pin) begin
      pin_wr_data <= '{pin:     head.body.pin.pin,
                       reg_sel: head.body.pin.reg_sel,
                       value:   head.body.pin.value};
    end
  end

  // decode must have filtered kind 3 upstream
  a_legal_kind : assert property (
    @(posedge sys_clk) disable iff (global_clock_reset)
    pop |-> (head.body.ctrl.kind inside {KIND_PIN, KIND_TIME_RESTART, KIND_SAMPLE})
  ) else $error("illegal command kind reached scheduler");

endmodule

`default_nettype wire

/* hdl/pin_ctrl.sv */
// one waveform pin, mode period and duty registers driving a phase counter
`timescale 1ns/10ps
`default_nettype none

module pin_ctrl #(
  parameter logic [3:0] POSITION = 4'd0
) (
  input  wire                         sys_clk,
  input  wire                         global_clock_reset,
  input  wire                         pin_wr,
  input  wire mecobo_pkg::pin_write_t pin_wr_data,
  output logic                        pin
);

  import mecobo_pkg::*;

  wave_mode_e  mode;
  logic [15:0] period;
  logic [15:0] duty;
  logic [15:0] phase;
  logic        sel;
  logic        restart;
  logic        level;

  // broadcast write, only our own index counts
  assign sel = pin_wr && (pin_wr_data.pin == POSITION);

  // mode or period change restarts the phase
  assign restart = sel && (pin_wr_data.reg_sel inside {REG_MODE, REG_PERIOD});

  // register file
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      mode   <= WAVE_LOW;
      period <= '0;
      duty   <= '0;
    end else if (sel) begin
      case (pin_wr_data.reg_sel)
        REG_MODE:   mode   <= wave_mode_e'(pin_wr_data.value[1:0]);
        REG_PERIOD: period <= pin_wr_data.value;
        REG_DUTY:   duty   <= pin_wr_data.value;
        default:    ;
      endcase
    end
  end

  // phase counter, wraps at period - 1
  // zero period parks it at 0
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      phase <= '0;
    end else if (restart || period == 16'd0) begin
      phase <= '0;
    end else if (phase >= period - 16'd1) begin
      phase <= '0;
    end else begin
      phase <= phase + 16'd1;
    end
  end

  // level from current phase
  always_comb begin
    case (mode)
      WAVE_HIGH:   level = 1'b1;
      // high for the first half, integer halving
      WAVE_SQUARE: level = (phase < (period >> 1));
      WAVE_PWM:    level = (phase < duty);
      default:     level = 1'b0;
    endcase
  end

  // registered output
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      pin <= 1'b0;
    end else begin
      pin <= level;
    end
  end

endmodule

`default_nettype wire

/* hdl/sample_result.sv */
// result queue and host result port with four-phase handshake
`timescale 1ns/10ps
`default_nettype none

module sample_result (
  input  wire                          sys_clk,
  input  wire                          global_clock_reset,
  input  wire                          rec_push,
  input  wire mecobo_pkg::sample_rec_t rec_data,
  output logic                         rec_full,
  output logic                         res_req,
  output mecobo_pkg::sample_rec_t      res,
  input  wire                          res_ack
);

  import mecobo_pkg::*;

  // idle, request out, waiting for ack to drop
  typedef enum logic [1:0] {RS_IDLE, RS_REQ, RS_DROP} res_state_e;

  res_state_e state;
  sample_rec_t mem [RES_DEPTH];
  logic [$clog2(RES_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(RES_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(RES_DEPTH+1)-1:0] count;
  logic discard;

  assign rec_full = (count == RES_DEPTH);
  assign res_req  = (state == RS_REQ);
  // record leaves the queue when the ack is seen
  assign discard  = (state == RS_REQ) && res_ack;

  always_ff @(posedge sys_clk) begin
    if (rec_push) mem[wr_ptr] <= rec_data;
    // oldest record latched as the request goes up
    if (state == RS_IDLE && count != 0) res <= mem[rd_ptr];
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      state  <= RS_IDLE;
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      case (state)
        RS_IDLE: if (count != 0) state <= RS_REQ;
        RS_REQ:  if (res_ack) state <= RS_DROP;
        default: if (!res_ack) state <= RS_IDLE;
      endcase
      if (rec_push) wr_ptr <= wr_ptr + 1'b1;
      if (discard)  rd_ptr <= rd_ptr + 1'b1;
      if (rec_push && !discard) count <= count + 1'b1;
      else if (discard && !rec_push) count <= count - 1'b1;
    end
  end

  // offered record stays put and still matches the queued oldest entry
  a_res_stable : assert property (
    @(posedge sys_clk) disable iff (global_clock_reset)
    res_req |=> (!res_req || ($stable(res) && res == mem[rd_ptr]))
  ) else $error("res changed or lost its queued record while res_req high");

endmodule

`default_nettype wire

/* hdl/mecobo_core.sv */
// command path top, decode into queue, scheduler, pin controllers and results
`timescale 1ns/10ps
`default_nettype none

module mecobo_core (
  input  wire                            sys_clk,
  input  wire                            global_clock_reset,
  input  wire                            cmd_req,
  input  wire mecobo_pkg::sched_cmd_t    cmd,
  output wire                            cmd_ack,
  output wire                            bad_cmd,
  output wire                            res_req,
  output mecobo_pkg::sample_rec_t        res,
  input  wire                            res_ack,
  output wire [mecobo_pkg::NUM_PINS-1:0] pins
);

  import mecobo_pkg::*;

  // decode to queue
  logic       push;
  sched_cmd_t push_data;
  logic       fifo_full;
  // queue to scheduler
  sched_cmd_t head;
  logic       empty;
  logic       pop;
  // scheduler to pins
  logic       pin_wr;
  pin_write_t pin_wr_data;
  // scheduler to results
  logic        rec_push;
  sample_rec_t rec_data;
  logic        rec_full;

  host_cmd_decode decode_i (
    .sys_clk, .global_clock_reset, .cmd_req, .cmd, .cmd_ack, .bad_cmd,
    .fifo_full, .push, .push_data
  );

  cmd_fifo fifo_i (
    .sys_clk, .global_clock_reset, .push, .push_data, .pop, .head,
    .full(fifo_full), .empty
  );

  sched_execute sched_i (
    .sys_clk, .global_clock_reset, .head, .empty, .pop, .pin_wr,
    .pin_wr_data, .pins, .rec_full, .rec_push, .rec_data
  );

  // one controller per pin, write broadcast to all
  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
    pin_ctrl #(.POSITION(4'(i))) pin_i (
      .sys_clk, .global_clock_reset, .pin_wr, .pin_wr_data, .pin(pins[i])
    );
  end

  sample_result result_i (
    .sys_clk, .global_clock_reset, .rec_push, .rec_data, .rec_full,
    .res_req, .res, .res_ack
  );

endmodule

`default_nettype wire

/* verification/mecobo_tb.sv */
// testbench for the command path, random scheduled commands checked against a cycle model
`timescale 1ns/10ps
`default_nettype none

module mecobo_tb;

  import mecobo_pkg::*;

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 2000;

  logic                sys_clk;
  logic                global_clock_reset;
  logic                cmd_req;
  sched_cmd_t          cmd;
  wire                 cmd_ack;
  wire                 bad_cmd;
  wire                 res_req;
  sample_rec_t         res;
  logic                res_ack;
  wire [NUM_PINS-1:0]  pins;

  integer seed;
  time_t  last_start;
  logic   hold_ack;

  // reference model, updated in the middle of each cycle
  logic                model_on;
  time_t               m_now;
  sched_cmd_t          mq[$];
  sample_rec_t         exp_q[$];
  int                  m_count;
  int                  restarts;
  logic                discard_next;
  logic                pw_valid;
  pin_write_t          pw_data;
  wave_mode_e          m_mode [NUM_PINS];
  logic [15:0]         m_period [NUM_PINS];
  logic [15:0]         m_duty [NUM_PINS];
  logic [15:0]         m_phase [NUM_PINS];
  logic [NUM_PINS-1:0] m_pin;

  mecobo_core dut_i (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset), .cmd_req(cmd_req),
    .cmd(cmd), .cmd_ack(cmd_ack), .bad_cmd(bad_cmd), .res_req(res_req), .res(res),
    .res_ack(res_ack), .pins(pins)
  );

  initial sys_clk = 1'b0;
  always #50 sys_clk = ~sys_clk;

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
    abort_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("FAILED %s: got %h expected %h", name, got, want);
      abort_run();
    end
  endtask

  task automatic check_pins(input string name, input logic [NUM_PINS-1:0] got,
                            input logic [NUM_PINS-1:0] want);
    if (got !== want) begin
      $display("FAILED %s: got %h expected %h", name, got, want);
      abort_run();
    end
  endtask

  task automatic check_rec(input string name, input sample_rec_t got, input sample_rec_t want);
    if (got !== want) begin
      $display("FAILED %s: got %h expected %h", name, got, want);
      abort_run();
    end
  endtask

  // level from the waveform rules
  function automatic logic wave_level(input wave_mode_e mode, input logic [15:0] period,
                                      input logic [15:0] duty, input logic [15:0] phase);
    case (mode)
      WAVE_HIGH:   return 1'b1;
      WAVE_SQUARE: return phase < (period / 16'd2);
      WAVE_PWM:    return phase < duty;
      default:     return 1'b0;
    endcase
  endfunction

  // strictly rising start times, always ahead of the current time
  function automatic time_t next_start();
    time_t base;
    base = (last_start > m_now) ? last_start : m_now;
    last_start = base + 32'd40 + 32'($unsigned($random(seed)) % 16);
    return last_start;
  endfunction

  function automatic sched_cmd_t pin_cmd(input time_t start);
    sched_cmd_t c;
    c.start = start;
    c.body.pin.kind = KIND_PIN;
    c.body.pin.pin = 4'($random(seed));
    c.body.pin.reg_sel = pin_reg_e'(2'($unsigned($random(seed)) % 3));
    c.body.pin.pad = 8'h00;
    // short periods so the waves turn over between commands
    if (c.body.pin.reg_sel == REG_MODE) begin
      c.body.pin.value = 16'($unsigned($random(seed)) % 4);
    end else begin
      c.body.pin.value = 16'($unsigned($random(seed)) % 24);
    end
    return c;
  endfunction

  function automatic sched_cmd_t ctrl_cmd(input time_t start, input logic [1:0] kind);
    sched_cmd_t c;
    c.start = start;
    c.body.ctrl.kind = kind;
    c.body.ctrl.reserved = 30'($random(seed));
    return c;
  endfunction

  task automatic drive_cmd(input sched_cmd_t c);
    cmd = c;
    cmd_req = 1'b1;
  endtask

  // finish the handshake; the FIFO took the command on the edge before ack showed
  task automatic complete_cmd(input sched_cmd_t c);
    int n;
    n = 0;
    while (cmd_ack !== 1'b1) begin
      if (n == WAIT_LIMIT) timeout_fail("cmd_ack to rise");
      n++;
      @(posedge sys_clk);
      #1;
    end
    // kind 3 is acked but never queued
    if (c.body.ctrl.kind != 2'd3) mq.push_back(c);
    cmd_req = 1'b0;
    n = 0;
    while (cmd_ack !== 1'b0) begin
      if (n == WAIT_LIMIT) timeout_fail("cmd_ack to fall");
      n++;
      @(posedge sys_clk);
      #1;
    end
  endtask

  task automatic send_cmd(input sched_cmd_t c);
    drive_cmd(c);
    complete_cmd(c);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (mq.size() != 0 || exp_q.size() != 0 || m_count != 0 || res_req !== 1'b0) begin
      if (n == WAIT_LIMIT) timeout_fail("all commands executed and results drained");
      n++;
      @(posedge sys_clk);
      #1;
    end
  endtask

  task automatic wait_restart();
    int n;
    n = 0;
    while (restarts == 0) begin
      if (n == WAIT_LIMIT) timeout_fail("the time restart to execute");
      n++;
      @(posedge sys_clk);
      #1;
    end
  endtask

  // model step, mid cycle while everything is stable
  always @(negedge sys_clk) begin : model_step
    logic       exec;
    logic       sel;
    logic       pw_new_valid;
    pin_write_t pw_new;
    sched_cmd_t h;
    logic [NUM_PINS-1:0] nxt;
    if (model_on) begin
      check_pins("pins", pins, m_pin);
      exec = 1'b0;
      pw_new_valid = 1'b0;
      pw_new = '0;
      h = '0;
      // head runs once due, a sample also needs room for its record
      if (mq.size() > 0) begin
        h = mq[0];
        if (h.start <= m_now &&
            !(h.body.ctrl.kind == KIND_SAMPLE && m_count == RES_DEPTH)) begin
          exec = 1'b1;
        end
      end
      if (exec) begin
        h = mq.pop_front();
        if (h.body.ctrl.kind == KIND_SAMPLE) begin
          exp_q.push_back('{stamp: m_now, levels: m_pin});
          m_count++;
        end else if (h.body.ctrl.kind == KIND_PIN) begin
          pw_new = '{pin: h.body.pin.pin, reg_sel: h.body.pin.reg_sel,
                     value: h.body.pin.value};
          pw_new_valid = 1'b1;
        end else begin
          restarts++;
        end
      end
      // pins see the write strobed one cycle after execution
      for (int i = 0; i < NUM_PINS; i++) begin
        nxt[i] = wave_level(m_mode[i], m_period[i], m_duty[i], m_phase[i]);
        sel = pw_valid && (pw_data.pin == 4'(i));
        if ((sel && pw_data.reg_sel != REG_DUTY) || m_period[i] == 16'd0) begin
          m_phase[i] = 16'd0;
        end else if ({1'b0, m_phase[i]} + 17'd1 >= {1'b0, m_period[i]}) begin
          m_phase[i] = 16'd0;
        end else begin
          m_phase[i] = m_phase[i] + 16'd1;
        end
        if (sel && pw_data.reg_sel == REG_MODE) m_mode[i] = wave_mode_e'(pw_data.value[1:0]);
        if (sel && pw_data.reg_sel == REG_PERIOD) m_period[i] = pw_data.value;
        if (sel && pw_data.reg_sel == REG_DUTY) m_duty[i] = pw_data.value;
      end
      m_pin = nxt;
      pw_valid = pw_new_valid;
      pw_data = pw_new;
      m_now = (exec && h.body.ctrl.kind == KIND_TIME_RESTART) ? 32'd0 : m_now + 32'd1;
      // record leaves the queue on the edge that sees the ack
      if (discard_next) m_count--;
      discard_next = 1'b0;
    end
  end

  // host side of the result port
  initial begin : result_drain
    int n;
    sample_rec_t want;
    forever begin
      @(posedge sys_clk);
      #1;
      if (!hold_ack && exp_q.size() > 0) begin
        n = 0;
        while (res_req !== 1'b1) begin
          if (n == WAIT_LIMIT) timeout_fail("res_req to rise");
          n++;
          @(posedge sys_clk);
          #1;
        end
        want = exp_q.pop_front();
        check_rec("res", res, want);
        res_ack = 1'b1;
        discard_next = 1'b1;
        n = 0;
        while (res_req !== 1'b0) begin
          if (n == WAIT_LIMIT) timeout_fail("res_req to fall");
          n++;
          @(posedge sys_clk);
          #1;
        end
        res_ack = 1'b0;
      end
    end
  end

  initial begin : stimulus
    sched_cmd_t held;
    seed = 32'h29e7_bc0b;
    global_clock_reset = 1'b1;
    cmd_req = 1'b0;
    cmd = '0;
    res_ack = 1'b0;
    hold_ack = 1'b0;
    last_start = '0;
    model_on = 1'b0;
    m_now = '0;
    m_count = 0;
    restarts = 0;
    discard_next = 1'b0;
    pw_valid = 1'b0;
    pw_data = '0;
    m_pin = '0;
    for (int i = 0; i < NUM_PINS; i++) begin
      m_mode[i] = WAVE_LOW;
      m_period[i] = '0;
      m_duty[i] = '0;
      m_phase[i] = '0;
    end
    repeat (8) @(posedge sys_clk);
    #1;
    global_clock_reset = 1'b0;
    model_on = 1'b1;
    check_bit("cmd_ack", cmd_ack, 1'b0);
    check_bit("res_req", res_req, 1'b0);
    check_bit("bad_cmd", bad_cmd, 1'b0);

    // mixed pin writes and samples on schedule
    for (int k = 0; k < 48; k++) begin
      if (($unsigned($random(seed)) % 5) < 3) begin
        send_cmd(pin_cmd(next_start()));
      end else begin
        send_cmd(ctrl_cmd(next_start(), KIND_SAMPLE));
      end
    end
    wait_idle();

    // restart, then a sample at a small start time
    send_cmd(ctrl_cmd(next_start(), KIND_TIME_RESTART));
    wait_restart();
    last_start = '0;
    send_cmd(ctrl_cmd(next_start(), KIND_SAMPLE));
    wait_idle();

    // results held back until the command FIFO is full
    hold_ack = 1'b1;
    for (int k = 0; k < 12; k++) begin
      send_cmd(ctrl_cmd(next_start(), KIND_SAMPLE));
    end
    held = ctrl_cmd(next_start(), KIND_SAMPLE);
    drive_cmd(held);
    repeat (60) begin
      @(posedge sys_clk);
      #1;
      check_bit("cmd_ack", cmd_ack, 1'b0);
    end
    hold_ack = 1'b0;
    complete_cmd(held);
    wait_idle();

    // kind 3 acked, flagged, never run
    send_cmd(ctrl_cmd(next_start(), 2'd3));
    check_bit("bad_cmd", bad_cmd, 1'b1);
    send_cmd(pin_cmd(next_start()));
    send_cmd(ctrl_cmd(next_start(), KIND_SAMPLE));
    wait_idle();
    check_bit("bad_cmd", bad_cmd, 1'b1);

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
hdl/mecobo_pkg.sv
hdl/host_cmd_decode.sv
hdl/cmd_fifo.sv
hdl/sched_execute.sv
hdl/pin_ctrl.sv
hdl/sample_result.sv
hdl/mecobo_core.sv
verification/mecobo_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the command path testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module mecobo_tb -f list.f -o mecobo_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/mecobo_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides
if grep -q "^Everything OK$" "$SIM_LOG"; then
  exit 0
fi
exit 1
